//--- bench/decode_stage_tb.sv
module decode_stage_tb;
    import decode_pkg::*;

    // stimulus runs about 650 cycles
    localparam int max_cycles = 2000;

    logic        clk = 1'b0;
    logic        rst;
    if_id_t      fetch;
    logic [31:0] inst;
    stall_t      stall;
    fwd_t        ex_fwd;
    fwd_t        mem_fwd;
    fwd_t        wb;
    logic        ex_load;
    id_ex_t      id_ex;
    br_t         br;
    logic        stall_req;

    integer      seed = 32'h7116;
    int          cycle_count = 0;
    logic [31:0] reg_model [32];
    logic        exp_stall;

    // random instruction fields
    logic [4:0]  f_rs;
    logic [4:0]  f_rt;
    logic [4:0]  f_rd;
    logic [4:0]  f_sa;
    logic [15:0] f_imm;
    logic [25:0] f_idx;

    logic [31:0] pc;
    logic [31:0] pc4;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic        exp_taken;
    logic [31:0] exp_target;
    logic [31:0] br_word;
    string       br_name;

    decode_stage DUT (
        .clk       (clk),
        .rst       (rst),
        .fetch     (fetch),
        .inst      (inst),
        .stall     (stall),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb        (wb),
        .ex_load   (ex_load),
        .id_ex     (id_ex),
        .br        (br),
        .stall_req (stall_req)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // register contents as seen one cycle after a wb write
    always @(posedge clk) begin
        if (wb.we) begin
            reg_model[wb.waddr] <= wb.wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] exp,
            input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        $display("** FAIL **");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
            else report_mismatch(name, exp, act);
    endtask

    // load in EX feeding a nonzero rs or rt of the slot
    always_comb begin
        exp_stall = ex_load && ex_fwd.we && (ex_fwd.waddr != 5'd0)
            && (ex_fwd.waddr == inst[25:21] || ex_fwd.waddr == inst[20:16]);
    end

    load_use: assert property (@(negedge clk) disable iff (rst) stall_req == exp_stall)
        else report_mismatch("load_use stall_req", 32'(exp_stall), 32'(stall_req));

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_pc();
        logic [31:0] v;
        v = $random(seed);
        return {v[31:2], 2'b00};
    endfunction

    task automatic draw_fields();
        f_rs  = 5'($random(seed));
        f_rt  = 5'($random(seed));
        f_rd  = 5'($random(seed));
        f_sa  = 5'($random(seed));
        f_imm = 16'($random(seed));
        f_idx = 26'($random(seed));
    endtask

    function automatic logic [31:0] r_word(input funct_e fn);
        return {op_special, f_rs, f_rt, f_rd, f_sa, fn};
    endfunction

    function automatic logic [31:0] i_word(input opcode_e op);
        return {op, f_rs, f_rt, f_imm};
    endfunction

    function automatic logic [31:0] j_word(input opcode_e op);
        return {op, f_idx};
    endfunction

    // fetch at one edge, the word arrives with IF/ID at the next
    task automatic issue(input logic [31:0] pc_in, input logic [31:0] word);
        @(posedge clk);
        fetch.valid <= 1'b1;
        fetch.pc    <= pc_in;
        @(posedge clk);
        inst <= word;
        @(negedge clk);
    endtask

    // flags are {mem_en, mem_we, rf_we}
    task automatic check_controls(input string name, input logic [31:0] word,
            input alu_op_e alu, input src1_sel_e s1, input src2_sel_e s2,
            input logic [2:0] flags, input logic [4:0] waddr);
        issue(rand_pc(), word);
        compare({name, " inst"}, word, id_ex.inst);
        compare({name, " alu_op"}, 32'(alu), 32'(id_ex.alu_op));
        compare({name, " src1_sel"}, 32'(s1), 32'(id_ex.src1_sel));
        compare({name, " src2_sel"}, 32'(s2), 32'(id_ex.src2_sel));
        compare({name, " mem_en"}, 32'(flags[2]), 32'(id_ex.mem_en));
        compare({name, " mem_we"}, 32'(flags[1]), 32'(id_ex.mem_we));
        compare({name, " rf_we"}, 32'(flags[0]), 32'(id_ex.rf_we));
        compare({name, " rf_waddr"}, 32'(waddr), 32'(id_ex.rf_waddr));
    endtask

    task automatic check_branch(input string name, input logic [31:0] word,
            input logic [31:0] pc_in, input logic taken, input logic [31:0] target);
        issue(pc_in, word);
        compare({name, " taken"}, 32'(taken), 32'(br.taken));
        compare({name, " target"}, target, br.target);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst     <= 1'b1;
        fetch   <= '0;
        stall   <= '0;
        ex_fwd  <= '0;
        mem_fwd <= '0;
        wb      <= '0;
        ex_load <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = 32'd0;
        end
        draw_fields();
        // jal on the bus while the slot is still empty
        inst <= j_word(op_jal);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare("reset rf_we", 32'd0, 32'(id_ex.rf_we));
        compare("reset mem_en", 32'd0, 32'(id_ex.mem_en));
        compare("reset taken", 32'd0, 32'(br.taken));

        // bubble
        issue(32'h0000_1000, j_word(op_jal));
        @(posedge clk);
        stall.hold_if <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        compare("bubble pc", 32'd0, id_ex.pc);
        compare("bubble rf_we", 32'd0, 32'(id_ex.rf_we));
        compare("bubble mem_en", 32'd0, 32'(id_ex.mem_en));
        compare("bubble taken", 32'd0, 32'(br.taken));
        @(posedge clk);
        stall.hold_if <= 1'b0;

        // full hold keeps the slot
        issue(32'h0000_2000, i_word(op_lw));
        @(posedge clk);
        stall.hold_if <= 1'b1;
        stall.hold_id <= 1'b1;
        fetch.pc      <= 32'h0000_3000;
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare("hold pc", 32'h0000_2000, id_ex.pc);
        compare("hold mem_en", 32'd1, 32'(id_ex.mem_en));
        @(posedge clk);
        stall <= '0;

        repeat (4) begin
            draw_fields();
            check_controls("addu", r_word(fn_addu), alu_add, src1_rs, src2_rt, 3'b001, f_rd);
            check_controls("subu", r_word(fn_subu), alu_sub, src1_rs, src2_rt, 3'b001, f_rd);
            check_controls("and", r_word(fn_and), alu_and, src1_rs, src2_rt, 3'b001, f_rd);
            check_controls("or", r_word(fn_or), alu_or, src1_rs, src2_rt, 3'b001, f_rd);
            check_controls("xor", r_word(fn_xor), alu_xor, src1_rs, src2_rt, 3'b001, f_rd);
            check_controls("nor", r_word(fn_nor), alu_nor, src1_rs, src2_rt, 3'b001, f_rd);
            check_controls("slt", r_word(fn_slt), alu_slt, src1_rs, src2_rt, 3'b001, f_rd);
            check_controls("sltu", r_word(fn_sltu), alu_sltu, src1_rs, src2_rt, 3'b001, f_rd);
            check_controls("sll", r_word(fn_sll), alu_sll, src1_sa, src2_rt, 3'b001, f_rd);
            check_controls("srl", r_word(fn_srl), alu_srl, src1_sa, src2_rt, 3'b001, f_rd);
            check_controls("sra", r_word(fn_sra), alu_sra, src1_sa, src2_rt, 3'b001, f_rd);
            check_controls("jr", r_word(fn_jr), alu_add, src1_rs, src2_rt, 3'b000, 5'd0);
            check_controls("addiu", i_word(op_addiu), alu_add, src1_rs, src2_imm_sx, 3'b001, f_rt);
            check_controls("andi", i_word(op_andi), alu_and, src1_rs, src2_imm_zx, 3'b001, f_rt);
            check_controls("ori", i_word(op_ori), alu_or, src1_rs, src2_imm_zx, 3'b001, f_rt);
            check_controls("xori", i_word(op_xori), alu_xor, src1_rs, src2_imm_zx, 3'b001, f_rt);
            check_controls("lui", i_word(op_lui), alu_lui, src1_rs, src2_imm_sx, 3'b001, f_rt);
            check_controls("slti", i_word(op_slti), alu_slt, src1_rs, src2_imm_sx, 3'b001, f_rt);
            check_controls("sltiu", i_word(op_sltiu), alu_sltu, src1_rs, src2_imm_sx, 3'b001,
                f_rt);
            check_controls("lw", i_word(op_lw), alu_add, src1_rs, src2_imm_sx, 3'b101, f_rt);
            check_controls("sw", i_word(op_sw), alu_add, src1_rs, src2_imm_sx, 3'b110, 5'd0);
            check_controls("beq", i_word(op_beq), alu_add, src1_rs, src2_rt, 3'b000, 5'd0);
            check_controls("bne", i_word(op_bne), alu_add, src1_rs, src2_rt, 3'b000, 5'd0);
            check_controls("j", j_word(op_j), alu_add, src1_rs, src2_rt, 3'b000, 5'd0);
            check_controls("jal", j_word(op_jal), alu_add, src1_pc, src2_eight, 3'b001, 5'd31);
        end

        // every register through wb, visible at once via the bypass
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            op_a = $random(seed);
            wb   <= {1'b1, 5'(i), op_a};
            inst <= {op_special, 5'(i), 5'(i), 10'd0, fn_addu};
            @(negedge clk);
            compare("wb bypass rs", (i == 0) ? 32'd0 : op_a, id_ex.rs_val);
            compare("wb bypass rt", (i == 0) ? 32'd0 : op_a, id_ex.rt_val);
        end
        @(posedge clk);
        wb.we <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            inst <= {op_special, 5'(i), 5'(31 - i), 10'd0, fn_addu};
            @(negedge clk);
            compare("readback rs", (i == 0) ? 32'd0 : reg_model[i], id_ex.rs_val);
            compare("readback rt", (i == 31) ? 32'd0 : reg_model[31 - i], id_ex.rt_val);
        end

        // ex over mem over wb over the file
        f_rs = 5'($random(seed)) | 5'd1;
        @(posedge clk);
        inst    <= {op_special, f_rs, 5'd0, 10'd0, fn_addu};
        ex_fwd  <= {1'b1, f_rs, 32'h1111_1111};
        mem_fwd <= {1'b1, f_rs, 32'h2222_2222};
        wb      <= {1'b1, f_rs, 32'h3333_3333};
        @(negedge clk);
        compare("priority ex", 32'h1111_1111, id_ex.rs_val);
        compare("priority rt zero", 32'd0, id_ex.rt_val);
        @(posedge clk);
        ex_fwd.we <= 1'b0;
        @(negedge clk);
        compare("priority mem", 32'h2222_2222, id_ex.rs_val);
        @(posedge clk);
        mem_fwd.we <= 1'b0;
        @(negedge clk);
        compare("priority wb", 32'h3333_3333, id_ex.rs_val);
        // idle wb carries other data than the file holds
        @(posedge clk);
        wb <= {1'b0, f_rs, 32'h4444_4444};
        @(negedge clk);
        compare("priority regfile", reg_model[f_rs], id_ex.rs_val);
        @(posedge clk);
        ex_fwd <= {1'b1, 5'd0, 32'hdead_beef};
        inst   <= {op_special, 5'd0, 5'd0, 10'd0, fn_addu};
        @(negedge clk);
        compare("zero register", 32'd0, id_ex.rs_val);

        // narrow index range so that matches are frequent
        repeat (150) begin
            @(posedge clk);
            ex_load <= 1'($random(seed));
            ex_fwd  <= {1'($random(seed)), 5'($random(seed)) & 5'd3, 32'($random(seed))};
            inst    <= {op_special, 5'($random(seed)) & 5'd3, 5'($random(seed)) & 5'd3,
                        10'd0, fn_addu};
        end
        @(posedge clk);
        ex_load <= 1'b0;
        ex_fwd  <= '0;

        // operands reach rs and rt through ex and mem bypass
        for (int n = 0; n < 60; n++) begin
            draw_fields();
            if (f_rs == 5'd0) begin
                f_rs = 5'd1;
            end
            f_rt = (f_rs == 5'd31) ? 5'd1 : f_rs + 5'd1;
            op_a = $random(seed);
            op_b = $random(seed);
            if (op_b[0]) begin
                op_b = op_a;
            end
            pc  = rand_pc();
            pc4 = pc + 32'd4;
            @(posedge clk);
            ex_fwd  <= {1'b1, f_rs, op_a};
            mem_fwd <= {1'b1, f_rt, op_b};
            case (n % 5)
                0: begin
                    br_name    = "beq";
                    br_word    = i_word(op_beq);
                    exp_taken  = (op_a == op_b);
                    exp_target = exp_taken ? pc4 + ({{16{f_imm[15]}}, f_imm} << 2) : 32'd0;
                end
                1: begin
                    br_name    = "bne";
                    br_word    = i_word(op_bne);
                    exp_taken  = (op_a != op_b);
                    exp_target = exp_taken ? pc4 + ({{16{f_imm[15]}}, f_imm} << 2) : 32'd0;
                end
                2: begin
                    br_name    = "j";
                    br_word    = j_word(op_j);
                    exp_taken  = 1'b1;
                    exp_target = {pc4[31:28], f_idx, 2'b00};
                end
                3: begin
                    br_name    = "jal";
                    br_word    = j_word(op_jal);
                    exp_taken  = 1'b1;
                    exp_target = {pc4[31:28], f_idx, 2'b00};
                end
                default: begin
                    br_name    = "jr";
                    br_word    = r_word(fn_jr);
                    exp_taken  = 1'b1;
                    exp_target = op_a;
                end
            endcase
            check_branch(br_name, br_word, pc, exp_taken, exp_target);
        end

        @(posedge clk);
        ex_fwd  <= '0;
        mem_fwd <= '0;
        repeat (2) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- hw/branch_unit.sv
module branch_unit (
    input  decode_pkg::br_op_e          br_op,
    input  logic [decode_pkg::xlen-1:0] pc,
    input  logic [decode_pkg::xlen-1:0] inst,
    input  logic [decode_pkg::xlen-1:0] rs_val,
    input  logic [decode_pkg::xlen-1:0] rt_val,
    output decode_pkg::br_t             br
);
    import decode_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] rel_target;
    logic [xlen-1:0] abs_target;
    logic            rs_eq_rt;

    assign pc_plus4   = pc + 32'd4;
    // word offset relative to the delay slot
    assign rel_target = pc_plus4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    // 256MB region of the delay slot
    assign abs_target = {pc_plus4[31:28], inst[25:0], 2'b00};
    assign rs_eq_rt   = (rs_val == rt_val);

    always_comb begin
        br.taken  = 1'b0;
        br.target = '0;
        case (br_op)
            br_beq: begin
                br.taken  = rs_eq_rt;
                br.target = rs_eq_rt ? rel_target : '0;
            end
            br_bne: begin
                br.taken  = !rs_eq_rt;
                br.target = rs_eq_rt ? '0 : rel_target;
            end
            br_j, br_jal: begin
                br.taken  = 1'b1;
                br.target = abs_target;
            end
            br_jr: begin
                br.taken  = 1'b1;
                br.target = rs_val;
            end
            default: ;
        endcase

        assert (br.taken || br.target == '0)
            else $error("branch_unit: nonzero target while not taken");
    end

endmodule

//--- hw/decode_pkg.sv
package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    ////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // SPECIAL function field
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    ////////////////////////////////////////////////////////////
    // control encodings toward EX and IF
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    // sa is zero-extended by EX
    typedef enum logic [1:0] {src1_rs, src1_pc, src1_sa} src1_sel_e;

    typedef enum logic [1:0] {src2_rt, src2_imm_sx, src2_eight, src2_imm_zx} src2_sel_e;

    typedef enum logic [2:0] {br_none, br_beq, br_bne, br_j, br_jal, br_jr} br_op_e;

    ////////////////////////////////////////////////////////////
    // stage buses
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
    } if_id_t;

    // one pending register write from a later stage
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } fwd_t;

    typedef struct packed {
        logic hold_if;
        logic hold_id;
    } stall_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       inst;
        alu_op_e               alu_op;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        logic                  mem_en;
        logic                  mem_we;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       rs_val;
        logic [xlen-1:0]       rt_val;
    } id_ex_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } br_t;

endpackage

//--- hw/decode_stage.sv
module decode_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  decode_pkg::if_id_t          fetch,
    input  logic [decode_pkg::xlen-1:0] inst,
    input  decode_pkg::stall_t          stall,
    input  decode_pkg::fwd_t            ex_fwd,
    input  decode_pkg::fwd_t            mem_fwd,
    input  decode_pkg::fwd_t            wb,
    input  logic                        ex_load,
    output decode_pkg::id_ex_t          id_ex,
    output decode_pkg::br_t             br,
    output logic                        stall_req
);
    import decode_pkg::*;

    if_id_t                if_id_r;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       rs_val;
    logic [xlen-1:0]       rt_val;
    alu_op_e               alu_op;
    src1_sel_e             src1_sel;
    src2_sel_e             src2_sel;
    logic                  mem_en;
    logic                  mem_we;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    br_op_e                br_op;

    ////////////////////////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////////////////////////

    // IF held but ID free -> insert a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_r <= '0;
        end else if (stall.hold_if && !stall.hold_id) begin
            if_id_r <= '0;
        end else if (!stall.hold_if) begin
            if_id_r <= fetch;
        end
    end

    // controller stalls back to front, never ID alone
    assert property (@(posedge clk) disable iff (rst) $rose(stall.hold_id) |-> stall.hold_if)
        else $error("decode_stage: hold_id rose without hold_if");

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    regfile #(
        .width  (xlen),
        .addr_w (reg_addr_w)
    ) u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wb.we),
        .waddr  (wb.waddr),
        .wdata  (wb.wdata)
    );

    inst_decoder u_inst_decoder (
        .inst     (inst),
        .valid    (if_id_r.valid),
        .rs       (rs),
        .rt       (rt),
        .alu_op   (alu_op),
        .src1_sel (src1_sel),
        .src2_sel (src2_sel),
        .mem_en   (mem_en),
        .mem_we   (mem_we),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .br_op    (br_op)
    );

    operand_forward u_operand_forward (
        .rs        (rs),
        .rt        (rt),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb        (wb),
        .ex_load   (ex_load),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .stall_req (stall_req)
    );

    branch_unit u_branch_unit (
        .br_op  (br_op),
        .pc     (if_id_r.pc),
        .inst   (inst),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .br     (br)
    );

    // bundle for EX
    always_comb begin
        id_ex.pc       = if_id_r.pc;
        id_ex.inst     = inst;
        id_ex.alu_op   = alu_op;
        id_ex.src1_sel = src1_sel;
        id_ex.src2_sel = src2_sel;
        id_ex.mem_en   = mem_en;
        id_ex.mem_we   = mem_we;
        id_ex.rf_we    = rf_we;
        id_ex.rf_waddr = rf_waddr;
        id_ex.rs_val   = rs_val;
        id_ex.rt_val   = rt_val;
    end

endmodule

//--- hw/inst_decoder.sv
module inst_decoder (
    input  logic [decode_pkg::xlen-1:0]       inst,
    input  logic                              valid,
    output logic [decode_pkg::reg_addr_w-1:0] rs,
    output logic [decode_pkg::reg_addr_w-1:0] rt,
    output decode_pkg::alu_op_e               alu_op,
    output decode_pkg::src1_sel_e             src1_sel,
    output decode_pkg::src2_sel_e             src2_sel,
    output logic                              mem_en,
    output logic                              mem_we,
    output logic                              rf_we,
    output logic [decode_pkg::reg_addr_w-1:0] rf_waddr,
    output decode_pkg::br_op_e                br_op
);
    import decode_pkg::*;

    opcode_e               opcode;
    funct_e                funct;
    logic [reg_addr_w-1:0] rd;
    logic                  r_alu;

    // field extraction
    assign opcode = opcode_e'(inst[31:26]);
    assign funct  = funct_e'(inst[5:0]);
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];

    ////////////////////////////////////////////////////////////
    // control generation
    ////////////////////////////////////////////////////////////

    always_comb begin
        alu_op   = alu_add;
        src1_sel = src1_rs;
        src2_sel = src2_rt;
        mem_en   = 1'b0;
        mem_we   = 1'b0;
        rf_we    = 1'b0;
        rf_waddr = '0;
        br_op    = br_none;
        r_alu    = 1'b0;

        if (valid) begin
            case (opcode)
                op_special: begin
                    r_alu = 1'b1;
                    case (funct)
                        fn_addu: alu_op = alu_add;
                        fn_subu: alu_op = alu_sub;
                        fn_and:  alu_op = alu_and;
                        fn_or:   alu_op = alu_or;
                        fn_xor:  alu_op = alu_xor;
                        fn_nor:  alu_op = alu_nor;
                        fn_slt:  alu_op = alu_slt;
                        fn_sltu: alu_op = alu_sltu;
                        // shift amount comes from the sa field
                        fn_sll: begin
                            alu_op   = alu_sll;
                            src1_sel = src1_sa;
                        end
                        fn_srl: begin
                            alu_op   = alu_srl;
                            src1_sel = src1_sa;
                        end
                        fn_sra: begin
                            alu_op   = alu_sra;
                            src1_sel = src1_sa;
                        end
                        fn_jr: begin
                            r_alu = 1'b0;
                            br_op = br_jr;
                        end
                        default: r_alu = 1'b0;
                    endcase
                    rf_we    = r_alu;
                    rf_waddr = r_alu ? rd : '0;
                end
                op_j: br_op = br_j;
                // link value is pc + 8 into r31
                op_jal: begin
                    br_op    = br_jal;
                    src1_sel = src1_pc;
                    src2_sel = src2_eight;
                    rf_we    = 1'b1;
                    rf_waddr = 5'd31;
                end
                op_beq: br_op = br_beq;
                op_bne: br_op = br_bne;
                op_addiu, op_slti, op_sltiu, op_lui: begin
                    src2_sel = src2_imm_sx;
                    rf_we    = 1'b1;
                    rf_waddr = rt;
                    case (opcode)
                        op_slti:  alu_op = alu_slt;
                        op_sltiu: alu_op = alu_sltu;
                        op_lui:   alu_op = alu_lui;
                        default:  alu_op = alu_add;
                    endcase
                end
                // logical immediates are zero-extended
                op_andi, op_ori, op_xori: begin
                    src2_sel = src2_imm_zx;
                    rf_we    = 1'b1;
                    rf_waddr = rt;
                    case (opcode)
                        op_andi: alu_op = alu_and;
                        op_ori:  alu_op = alu_or;
                        default: alu_op = alu_xor;
                    endcase
                end
                op_lw: begin
                    src2_sel = src2_imm_sx;
                    mem_en   = 1'b1;
                    rf_we    = 1'b1;
                    rf_waddr = rt;
                end
                op_sw: begin
                    src2_sel = src2_imm_sx;
                    mem_en   = 1'b1;
                    mem_we   = 1'b1;
                end
                default: ;
            endcase
        end

        assert (!mem_we || mem_en)
            else $error("inst_decoder: mem_we without mem_en");
    end

endmodule

//--- hw/operand_forward.sv
module operand_forward (
    input  logic [decode_pkg::reg_addr_w-1:0] rs,
    input  logic [decode_pkg::reg_addr_w-1:0] rt,
    input  logic [decode_pkg::xlen-1:0]       rdata1,
    input  logic [decode_pkg::xlen-1:0]       rdata2,
    input  decode_pkg::fwd_t                  ex_fwd,
    input  decode_pkg::fwd_t                  mem_fwd,
    input  decode_pkg::fwd_t                  wb,
    input  logic                              ex_load,
    output logic [decode_pkg::xlen-1:0]       rs_val,
    output logic [decode_pkg::xlen-1:0]       rt_val,
    output logic                              stall_req
);
    import decode_pkg::*;

    logic hit_rs;
    logic hit_rt;

    // youngest producer wins, r0 is hardwired
    function automatic logic [xlen-1:0] bypass(
        input logic [reg_addr_w-1:0] idx,
        input logic [xlen-1:0]       rf_val,
        input fwd_t                  ex_w,
        input fwd_t                  mem_w,
        input fwd_t                  wb_w
    );
        logic [xlen-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (ex_w.we && ex_w.waddr == idx) begin
            val = ex_w.wdata;
        end else if (mem_w.we && mem_w.waddr == idx) begin
            val = mem_w.wdata;
        end else if (wb_w.we && wb_w.waddr == idx) begin
            val = wb_w.wdata;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign rs_val = bypass(rs, rdata1, ex_fwd, mem_fwd, wb);
    assign rt_val = bypass(rt, rdata2, ex_fwd, mem_fwd, wb);

    ////////////////////////////////////////////////////////////
    // load-use hazard
    ////////////////////////////////////////////////////////////

    // load data is not ready until MEM, so wait one cycle
    assign hit_rs    = (ex_fwd.waddr == rs);
    assign hit_rt    = (ex_fwd.waddr == rt);
    assign stall_req = ex_load && ex_fwd.we && (ex_fwd.waddr != '0) && (hit_rs || hit_rt);

endmodule

//--- hw/regfile.sv
module regfile #(
    parameter int width  = 32,
    parameter int addr_w = 5
) (
    input  logic              clk,
    input  logic [addr_w-1:0] raddr1,
    input  logic [addr_w-1:0] raddr2,
    output logic [width-1:0]  rdata1,
    output logic [width-1:0]  rdata2,
    input  logic              we,
    input  logic [addr_w-1:0] waddr,
    input  logic [width-1:0]  wdata
);

    localparam int depth = 1 << addr_w;

    logic [width-1:0] mem [depth];

    // write-back port, visible to reads the cycle after
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // entry 0 is masked downstream by the bypass logic
    assign rdata1 = mem[raddr1];
    assign rdata2 = mem[raddr2];

endmodule

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sources.f --top-module decode_stage_tb

./obj_dir/Vdecode_stage_tb > sim.log 2>&1 || true
cat sim.log

grep -qF '** PASS **' sim.log
echo "simulation passed"

//--- sources.f
hw/decode_pkg.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/operand_forward.sv
hw/branch_unit.sv
hw/decode_stage.sv
bench/decode_stage_tb.sv
